//--- Makefile
VERILATOR ?= verilator
TOP       ?= memoryGameTb
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing
PASSTEXT  ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)

//--- hw/gameController.sv
`timescale 1ns/1ps
`default_nettype none

module gameController (
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire logic             start,
    input  wire logic             playMade,
    input  wire logic             playCorrect,
    input  wire logic             addrEqualsRound,
    input  wire logic             lastRound,
    input  wire logic             timerExpired,
    input  wire logic             showDone,
    output logic                  clearPlay,
    output logic                  loadPlay,
    output logic                  clearAddr,
    output logic                  countAddr,
    output logic                  clearRound,
    output logic                  countRound,
    output logic                  clearTimer,
    output logic                  countTimer,
    output logic                  clearShow,
    output logic                  countShow,
    output logic                  loadLevels,
    output logic                  showLeds,
    output logic                  won,
    output logic                  lost,
    output logic                  ready,
    output logic                  timedOut,
    output logic                  playerTurn,
    output segmentPkg::hexDigit_t dbState
);

    gamePkg::gameState_t state;
    gamePkg::gameState_t nextState;
    logic                waitingStart;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= gamePkg::idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        case (state)
            gamePkg::idle:       nextState = start ? gamePkg::prepare : gamePkg::idle;
            gamePkg::prepare:    nextState = gamePkg::showColour;
            gamePkg::showColour: nextState = showDone ? gamePkg::clearShow : gamePkg::showColour;
            gamePkg::clearShow:  nextState = gamePkg::waitPlay;
            gamePkg::waitPlay: begin
                // Running out of time wins over a late play
                if (timerExpired)  nextState = gamePkg::timeoutEnd;
                else if (playMade) nextState = gamePkg::storePlay;
                else               nextState = gamePkg::waitPlay;
            end
            gamePkg::storePlay:  nextState = gamePkg::compare;
            gamePkg::compare: begin
                if (!playCorrect)          nextState = gamePkg::lostEnd;
                else if (!addrEqualsRound) nextState = gamePkg::nextPlay;
                else if (lastRound)        nextState = gamePkg::wonEnd;
                else                       nextState = gamePkg::nextRound;
            end
            gamePkg::nextPlay:   nextState = gamePkg::waitPlay;
            gamePkg::nextRound:  nextState = gamePkg::showColour;
            gamePkg::wonEnd,
            gamePkg::lostEnd,
            gamePkg::timeoutEnd: nextState = start ? gamePkg::prepare : state;
            default:             nextState = gamePkg::idle;
        endcase
    end

    // Idle or finished, the next start begins a new game
    assign waitingStart = (state == gamePkg::idle) || (state == gamePkg::wonEnd) ||
                          (state == gamePkg::lostEnd) || (state == gamePkg::timeoutEnd);

    // Levels are taken on the same edge that leaves for prepare
    assign loadLevels = waitingStart && start;

    assign clearPlay  = (state == gamePkg::prepare);
    assign clearRound = (state == gamePkg::prepare);
    assign clearAddr  = (state == gamePkg::prepare) || (state == gamePkg::clearShow);
    assign clearTimer = (state == gamePkg::prepare) || (state == gamePkg::clearShow) ||
                        (state == gamePkg::nextPlay);
    assign clearShow  = (state == gamePkg::prepare) || (state == gamePkg::nextRound);
    assign countShow  = (state == gamePkg::showColour);
    assign showLeds   = (state == gamePkg::showColour);
    assign countTimer = (state == gamePkg::waitPlay);
    assign loadPlay   = (state == gamePkg::storePlay);
    assign countRound = (state == gamePkg::nextRound);
    // Address follows the round so the next colour is shown from it
    assign countAddr  = (state == gamePkg::nextPlay) || (state == gamePkg::nextRound);

    assign playerTurn = (state == gamePkg::waitPlay);
    assign won        = (state == gamePkg::wonEnd);
    assign lost       = (state == gamePkg::lostEnd);
    assign timedOut   = (state == gamePkg::timeoutEnd);
    assign ready      = won || lost || timedOut;

    assign dbState = segmentPkg::hexDigit_t'(state);

endmodule

`default_nettype wire

//--- hw/gameDatapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "memoryGame_defines.svh"

module gameDatapath (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire gamePkg::colour_t  switches,
    input  wire logic              roundsLevel,
    input  wire logic              timeLevel,
    input  wire logic              clearPlay,
    input  wire logic              loadPlay,
    input  wire logic              clearAddr,
    input  wire logic              countAddr,
    input  wire logic              clearRound,
    input  wire logic              countRound,
    input  wire logic              clearTimer,
    input  wire logic              countTimer,
    input  wire logic              clearShow,
    input  wire logic              countShow,
    input  wire logic              loadLevels,
    input  wire logic              showLeds,
    output logic                   playMade,
    output logic                   playCorrect,
    output logic                   addrEqualsRound,
    output logic                   lastRound,
    output logic                   timerExpired,
    output logic                   showDone,
    output logic                   roundsLevelReg,
    output logic                   timeLevelReg,
    output gamePkg::colour_t       leds,
    output logic                   dbHasPlay,
    output segmentPkg::hexDigit_t  dbCount,
    output segmentPkg::hexDigit_t  dbMemory,
    output segmentPkg::hexDigit_t  dbPlay
);

    localparam int AddrWidth  = $clog2(`ROM_DEPTH);
    localparam int TimerWidth = $clog2(`PLAY_TIMEOUT + 1);
    localparam int ShowWidth  = $clog2(`SHOW_CYCLES);

    logic [AddrWidth-1:0]  addrCount;
    logic [AddrWidth-1:0]  roundCount;
    logic [TimerWidth-1:0] playTimer;
    logic [ShowWidth-1:0]  showCount;
    gamePkg::colour_t      playReg;
    gamePkg::colour_t      romColour;
    logic                  anyPrev;
    logic                  playPulse;

    // Position of the lit bit, F when the value is not one-hot
    function automatic segmentPkg::hexDigit_t colourIndex(input gamePkg::colour_t colour);
        case (colour)
            4'b0001: return 4'h0;
            4'b0010: return 4'h1;
            4'b0100: return 4'h2;
            4'b1000: return 4'h3;
            default: return 4'hF;
        endcase
    endfunction

    sequenceRom i_sequenceRom (
        .addr   (addrCount),
        .colour (romColour)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            addrCount      <= '0;
            roundCount     <= '0;
            playTimer      <= '0;
            showCount      <= '0;
            playReg        <= '0;
            roundsLevelReg <= 1'b0;
            timeLevelReg   <= 1'b0;
            anyPrev        <= 1'b0;
            playPulse      <= 1'b0;
        end else begin
            if (clearAddr)       addrCount <= '0;
            else if (countAddr)  addrCount <= addrCount + 1'b1;
            if (clearRound)      roundCount <= '0;
            else if (countRound) roundCount <= roundCount + 1'b1;
            if (clearTimer)      playTimer <= '0;
            else if (countTimer) playTimer <= playTimer + 1'b1;
            if (clearShow)       showCount <= '0;
            else if (countShow)  showCount <= showCount + 1'b1;
            if (clearPlay)       playReg <= '0;
            else if (loadPlay)   playReg <= switches;
            if (loadLevels) begin
                roundsLevelReg <= roundsLevel;
                timeLevelReg   <= timeLevel;
            end
            // Rising edge of "any switch up", seen one cycle late
            anyPrev   <= |switches;
            playPulse <= (|switches) && !anyPrev;
        end
    end

    assign playMade        = playPulse;
    assign playCorrect     = (playReg == romColour);
    assign addrEqualsRound = (addrCount == roundCount);
    assign lastRound       = roundsLevelReg ? (roundCount == AddrWidth'(`ROUNDS_LONG - 1))
                                            : (roundCount == AddrWidth'(`ROUNDS_SHORT - 1));
    assign timerExpired    = timeLevelReg ? (playTimer == TimerWidth'(`PLAY_TIMEOUT / 2))
                                          : (playTimer == TimerWidth'(`PLAY_TIMEOUT));
    assign showDone        = (showCount == ShowWidth'(`SHOW_CYCLES - 1));
    assign leds            = showLeds ? romColour : '0;

    assign dbHasPlay = playPulse;
    assign dbCount   = segmentPkg::hexDigit_t'(addrCount);
    assign dbMemory  = colourIndex(romColour);
    assign dbPlay    = colourIndex(playReg);

endmodule

`default_nettype wire

//--- hw/gamePkg.sv
`default_nettype none

package gamePkg;

    // Controller states, value shown on the state display
    typedef enum logic [3:0] {
        idle       = 4'd0,
        prepare    = 4'd1,
        showColour = 4'd2,
        clearShow  = 4'd3,
        waitPlay   = 4'd4,
        storePlay  = 4'd5,
        compare    = 4'd6,
        nextPlay   = 4'd7,
        nextRound  = 4'd8,
        wonEnd     = 4'd10,
        lostEnd    = 4'd11,
        timeoutEnd = 4'd12
    } gameState_t;

    // One-hot colour, same coding for LEDs and switches
    typedef logic [3:0] colour_t;

endpackage

`default_nettype wire

//--- hw/hexDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module hexDecoder (
    input  wire segmentPkg::hexDigit_t hexa,
    output segmentPkg::segment_t       display
);

    // Patterns listed as gfedcba
    always_comb begin
        case (hexa)
            4'h0:    display = 7'b0111111;
            4'h1:    display = 7'b0000110;
            4'h2:    display = 7'b1011011;
            4'h3:    display = 7'b1001111;
            4'h4:    display = 7'b1100110;
            4'h5:    display = 7'b1101101;
            4'h6:    display = 7'b1111101;
            4'h7:    display = 7'b0000111;
            4'h8:    display = 7'b1111111;
            4'h9:    display = 7'b1101111;
            4'hA:    display = 7'b1110111;
            4'hB:    display = 7'b1111100;
            4'hC:    display = 7'b0111001;
            4'hD:    display = 7'b1011110;
            4'hE:    display = 7'b1111001;
            default: display = 7'b1110001;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/memoryGame.sv
`timescale 1ns/1ps
`default_nettype none

module memoryGame (
    input  wire logic            clock,
    input  wire logic            reset,
    input  wire logic            start,
    input  wire gamePkg::colour_t switches,
    input  wire logic            roundsLevel,
    input  wire logic            timeLevel,
    output logic                 won,
    output logic                 lost,
    output logic                 ready,
    output logic                 playerTurn,
    output logic                 timedOut,
    output gamePkg::colour_t     leds,
    output logic                 dbEqual,
    output segmentPkg::segment_t dbCount,
    output segmentPkg::segment_t dbMemory,
    output segmentPkg::segment_t dbState,
    output segmentPkg::segment_t dbPlay,
    output logic                 dbRoundsLevel,
    output logic                 dbTimeLevel,
    output logic                 dbClock,
    output logic                 dbStart,
    output logic                 dbHasPlay
);

    // Controller strobes
    logic clearPlay, loadPlay, clearAddr, countAddr, clearRound, countRound;
    logic clearTimer, countTimer, clearShow, countShow, loadLevels, showLeds;
    // Datapath conditions
    logic playMade, playCorrect, addrEqualsRound, lastRound, timerExpired, showDone;
    logic roundsLevelReg, timeLevelReg;
    // Nibbles for the displays
    segmentPkg::hexDigit_t countDigit, memoryDigit, stateDigit, playDigit;

    assign dbEqual       = playCorrect;
    assign dbRoundsLevel = roundsLevelReg;
    assign dbTimeLevel   = timeLevelReg;
    assign dbClock       = clock;
    assign dbStart       = start;

    gameDatapath i_gameDatapath (
        .clock, .reset, .switches, .roundsLevel, .timeLevel,
        .clearPlay, .loadPlay, .clearAddr, .countAddr, .clearRound, .countRound,
        .clearTimer, .countTimer, .clearShow, .countShow, .loadLevels, .showLeds,
        .playMade, .playCorrect, .addrEqualsRound, .lastRound, .timerExpired, .showDone,
        .roundsLevelReg, .timeLevelReg, .leds, .dbHasPlay,
        .dbCount  (countDigit),
        .dbMemory (memoryDigit),
        .dbPlay   (playDigit)
    );

    gameController i_gameController (
        .clock, .reset, .start,
        .playMade, .playCorrect, .addrEqualsRound, .lastRound, .timerExpired, .showDone,
        .clearPlay, .loadPlay, .clearAddr, .countAddr, .clearRound, .countRound,
        .clearTimer, .countTimer, .clearShow, .countShow, .loadLevels, .showLeds,
        .won, .lost, .ready, .timedOut, .playerTurn,
        .dbState (stateDigit)
    );

    hexDecoder i_countDisplay  (.hexa (countDigit),  .display (dbCount));
    hexDecoder i_memoryDisplay (.hexa (memoryDigit), .display (dbMemory));
    hexDecoder i_stateDisplay  (.hexa (stateDigit),  .display (dbState));
    hexDecoder i_playDisplay   (.hexa (playDigit),   .display (dbPlay));

endmodule

`default_nettype wire

//--- hw/segmentPkg.sv
`default_nettype none

package segmentPkg;

    // Nibble sent to a debug display
    typedef logic [3:0] hexDigit_t;

    // Seven-segment pattern, active high
    // Bit 0 is segment a, bit 6 is segment g
    typedef logic [6:0] segment_t;

endpackage

`default_nettype wire

//--- hw/sequenceRom.sv
`timescale 1ns/1ps
`default_nettype none

`include "memoryGame_defines.svh"

module sequenceRom (
    input  wire logic [$clog2(`ROM_DEPTH)-1:0] addr,
    output gamePkg::colour_t                   colour
);

    // Fixed sequence, one colour per round
    always_comb begin
        case (addr)
            4'h0:    colour = 4'b0001;
            4'h1:    colour = 4'b0010;
            4'h2:    colour = 4'b0100;
            4'h3:    colour = 4'b1000;
            4'h4:    colour = 4'b0100;
            4'h5:    colour = 4'b0010;
            4'h6:    colour = 4'b0001;
            4'h7:    colour = 4'b0001;
            4'h8:    colour = 4'b0010;
            4'h9:    colour = 4'b0010;
            4'hA:    colour = 4'b0100;
            4'hB:    colour = 4'b0100;
            4'hC:    colour = 4'b1000;
            4'hD:    colour = 4'b1000;
            4'hE:    colour = 4'b0001;
            default: colour = 4'b0100;
        endcase
    end

endmodule

`default_nettype wire

//--- include/memoryGame_defines.svh
`ifndef MEMORYGAME_DEFINES_SVH
`define MEMORYGAME_DEFINES_SVH

// Game length, chosen by roundsLevel at start
`define ROUNDS_SHORT 8
`define ROUNDS_LONG 16

// Entries in the colour sequence
`define ROM_DEPTH 16

// Response time per play, halved when timeLevel is latched high
`define PLAY_TIMEOUT 40

// How long a new colour stays lit
`define SHOW_CYCLES 6

`endif

//--- verif/memoryGameChecker.sv
`timescale 1ns/1ps
`default_nettype none

`include "memoryGame_defines.svh"

module memoryGameChecker (
    input  wire logic       clock,
    input  wire logic       reset,
    input  wire logic       start,
    input  wire logic [3:0] switches,
    input  wire logic       won,
    input  wire logic       lost,
    input  wire logic       ready,
    input  wire logic       playerTurn,
    input  wire logic       timedOut,
    input  wire logic [3:0] leds,
    input  wire logic       dbEqual,
    input  wire logic [6:0] dbCount,
    input  wire logic [6:0] dbMemory,
    input  wire logic [6:0] dbState,
    input  wire logic [6:0] dbPlay,
    input  wire logic       dbRoundsLevel,
    input  wire logic       dbTimeLevel,
    input  wire logic       dbClock,
    input  wire logic       dbStart,
    input  wire logic       dbHasPlay,
    input  wire logic [3:0] romImage [16],
    input  wire logic       resetCheck,
    input  var  int         testNum,
    input  var  int         expOutcome,
    input  var  int         expShows,
    input  var  int         expLimit,
    input  wire logic       expRoundsLevel,
    input  wire logic       expTimeLevel,
    output int              errorCount,
    output int              testCount
);

    int         testErrors;
    int         shows;
    int         showLen;
    int         pos;
    int         turnLen;
    int         lastTurnLen;
    bit         pendingPlay;
    logic [3:0] playVal;
    logic [3:0] prevLeds;
    logic [3:0] prevSwitches;
    logic [3:0] olderSwitches;
    logic       prevTurn;
    logic       prevReady;

    // Standard active-high digits, segment a in bit 0
    function automatic logic [6:0] segmentFor(input int digit);
        logic [6:0] table16 [16];
        table16 = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
                    7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};
        return table16[digit & 15];
    endfunction

    // Bit position of a one-hot play, 15 otherwise
    function automatic int indexOf(input logic [3:0] value);
        int found;
        int ones;
        found = 15;
        ones = 0;
        for (int b = 0; b < 4; b++) begin
            if (value[b]) begin
                ones++;
                found = b;
            end
        end
        return (ones == 1) ? found : 15;
    endfunction

    task automatic expectValue(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
            testErrors++;
            errorCount++;
        end
    endtask

    task automatic reportTest();
        testCount++;
        $display("Test %0d %s with %0d errors", testNum,
                 (testErrors == 0) ? "passed" : "failed", testErrors);
    endtask

    task automatic finishGame();
        expectValue("won", int'(expOutcome == 0), int'(won));
        expectValue("lost", int'(expOutcome == 1), int'(lost));
        expectValue("timedOut", int'(expOutcome == 2), int'(timedOut));
        expectValue("shown colours", expShows, shows);
        expectValue("dbRoundsLevel", int'(expRoundsLevel), int'(dbRoundsLevel));
        expectValue("dbTimeLevel", int'(expTimeLevel), int'(dbTimeLevel));
        if (expOutcome == 2 && (lastTurnLen < expLimit || lastTurnLen > expLimit + 3)) begin
            $display("Error at %0t ns: game timed out after %0d cycles, allowed %0d to %0d",
                     $time, lastTurnLen, expLimit, expLimit + 3);
            testErrors++;
            errorCount++;
        end
        reportTest();
    endtask

    initial begin
        errorCount = 0;
        testCount = 0;
        testErrors = 0;
    end

    // Raw clock copy, sampled between edges
    always @(clock) begin
        #2;
        expectValue("dbClock", int'(clock), int'(dbClock));
    end

    always @(negedge clock) begin
        if (reset) begin
            prevLeds = '0;
            prevSwitches = '0;
            olderSwitches = '0;
            prevTurn = 1'b0;
            prevReady = 1'b0;
            turnLen = 0;
            pendingPlay = 0;
        end else begin
            if (resetCheck) begin
                testErrors = 0;
                expectValue("won", 0, int'(won));
                expectValue("lost", 0, int'(lost));
                expectValue("ready", 0, int'(ready));
                expectValue("timedOut", 0, int'(timedOut));
                expectValue("playerTurn", 0, int'(playerTurn));
                expectValue("leds", 0, int'(leds));
                expectValue("dbState", int'(segmentFor(0)), int'(dbState));
                reportTest();
            end
            if (start) begin
                shows = 0;
                showLen = 0;
                pos = 0;
                testErrors = 0;
                pendingPlay = 0;
            end
            expectValue("dbStart", int'(start), int'(dbStart));
            // Play pulse comes one cycle after the switches leave zero
            expectValue("dbHasPlay", int'(prevSwitches != '0 && olderSwitches == '0),
                        int'(dbHasPlay));
            // A new colour begins when the LEDs light up from dark
            if (leds != '0) begin
                if (prevLeds == '0) begin
                    if (shows < 16)
                        expectValue("leds", int'(romImage[shows]), int'(leds));
                    shows++;
                    showLen = 0;
                    pos = 0;
                end
                showLen++;
            end else if (prevLeds != '0) begin
                expectValue("show length", `SHOW_CYCLES, showLen);
            end
            // Play register is visible one cycle after the turn ends
            if (pendingPlay) begin
                expectValue("dbPlay", int'(segmentFor(indexOf(playVal))), int'(dbPlay));
                expectValue("dbEqual", int'(playVal == romImage[pos & 15]), int'(dbEqual));
                expectValue("dbCount", int'(segmentFor(pos)), int'(dbCount));
                expectValue("dbMemory", int'(segmentFor(indexOf(romImage[pos & 15]))),
                            int'(dbMemory));
                pos++;
                pendingPlay = 0;
            end
            if (playerTurn) begin
                turnLen++;
            end else begin
                if (prevTurn) begin
                    lastTurnLen = turnLen;
                    if (!timedOut) begin
                        pendingPlay = 1;
                        playVal = switches;
                    end
                end
                turnLen = 0;
            end
            if (ready && !prevReady)
                finishGame();
            prevLeds = leds;
            olderSwitches = prevSwitches;
            prevSwitches = switches;
            prevTurn = playerTurn;
            prevReady = ready;
        end
    end

endmodule

`default_nettype wire

//--- verif/memoryGameTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "memoryGame_defines.svh"

module memoryGameTb;

    localparam int TurnLimit  = 60;
    localparam int ReadyLimit = 3000;

    logic       clock;
    logic       reset;
    logic       start;
    logic [3:0] switches;
    logic       roundsLevel;
    logic       timeLevel;
    logic       won, lost, ready, playerTurn, timedOut;
    logic [3:0] leds;
    logic       dbEqual, dbRoundsLevel, dbTimeLevel, dbClock, dbStart, dbHasPlay;
    logic [6:0] dbCount, dbMemory, dbState, dbPlay;

    logic [3:0] romImage [16];
    int         rsA [8], rdA [8], tlA [8], frA [8], fpA [8], ocA [8];
    int         scriptCount;
    bit         waitFailed;
    logic       resetCheck;
    int         testNum, expOutcome, expShows, expLimit;
    logic       expRoundsLevel;
    logic       expTimeLevel;
    int         errorCount, testCount;

    memoryGame i_memoryGame (
        .clock, .reset, .start, .switches, .roundsLevel, .timeLevel,
        .won, .lost, .ready, .playerTurn, .timedOut, .leds,
        .dbEqual, .dbCount, .dbMemory, .dbState, .dbPlay,
        .dbRoundsLevel, .dbTimeLevel, .dbClock, .dbStart, .dbHasPlay
    );

    memoryGameChecker i_checker (
        .clock, .reset, .start, .switches, .won, .lost, .ready, .playerTurn, .timedOut,
        .leds, .dbEqual, .dbCount, .dbMemory, .dbState, .dbPlay, .dbRoundsLevel,
        .dbTimeLevel, .dbClock, .dbStart, .dbHasPlay, .romImage, .resetCheck,
        .testNum, .expOutcome, .expShows, .expLimit, .expRoundsLevel, .expTimeLevel,
        .errorCount, .testCount
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic loadVectors();
        int    fd;
        int    a, b, c, d, e, f;
        string line;
        fd = $fopen("verif/memoryGame_vectors.txt", "r");
        scriptCount = 0;
        if (fd == 0) begin
            $display("Could not open the vectors file");
            waitFailed = 1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if ($sscanf(line, "R %h %h", a, b) == 2) begin
                    romImage[a & 15] = b[3:0];
                end else if ($sscanf(line, "T %h %h %h %h %h %h", a, b, c, d, e, f) == 6
                             && scriptCount < 8) begin
                    rsA[scriptCount] = a;
                    rdA[scriptCount] = b;
                    tlA[scriptCount] = c;
                    frA[scriptCount] = d;
                    fpA[scriptCount] = e;
                    ocA[scriptCount] = f;
                    scriptCount++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic waitTurnHigh();
        int cycles;
        cycles = 0;
        if (!waitFailed) begin
            @(negedge clock);
            while (!playerTurn && cycles < TurnLimit) begin
                @(negedge clock);
                cycles++;
            end
            if (!playerTurn) begin
                $display("Player turn never started in test %0d", testNum);
                waitFailed = 1;
            end
        end
    endtask

    task automatic waitTurnLow();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (playerTurn && cycles < 10) begin
            @(negedge clock);
            cycles++;
        end
        if (playerTurn) begin
            $display("Play was never accepted in test %0d", testNum);
            waitFailed = 1;
        end
    endtask

    task automatic waitReady();
        int cycles;
        cycles = 0;
        if (!waitFailed) begin
            @(negedge clock);
            while (!ready && cycles < ReadyLimit) begin
                @(negedge clock);
                cycles++;
            end
            if (!ready) begin
                $display("Game never ended in test %0d", testNum);
                waitFailed = 1;
            end
            repeat (2) @(negedge clock);
        end
    endtask

    // Repeat the sequence, with a wrong play or silence at the failing round
    task automatic playGame(input int rounds, input int failRound, input int failPlay);
        logic [3:0] play;
        int         gap;
        bit         stop;
        stop = 0;
        for (int r = 0; r < rounds && !stop && !waitFailed; r++) begin
            for (int p = 0; p <= r && !stop && !waitFailed; p++) begin
                waitTurnHigh();
                play = romImage[p];
                if (r == failRound && p == r) begin
                    stop = 1;
                    play = failPlay[3:0];
                end
                if (play != 4'hF && !waitFailed) begin
                    gap = $urandom_range(3, 0);
                    repeat (gap) @(posedge clock);
                    @(posedge clock);
                    switches <= play;
                    waitTurnLow();
                    @(posedge clock);
                    switches <= '0;
                end
            end
        end
    endtask

    task automatic runScript(input int i);
        int rounds;
        rounds = (rsA[i] != 0) ? `ROUNDS_LONG : `ROUNDS_SHORT;
        @(posedge clock);
        start          <= 1'b1;
        roundsLevel    <= rsA[i][0];
        timeLevel      <= tlA[i][0];
        testNum        <= i + 2;
        expOutcome     <= ocA[i];
        expShows       <= (ocA[i] == 0) ? rounds : frA[i] + 1;
        expLimit       <= (tlA[i] != 0) ? `PLAY_TIMEOUT / 2 : `PLAY_TIMEOUT;
        expRoundsLevel <= rsA[i][0];
        expTimeLevel   <= tlA[i][0];
        @(posedge clock);
        start       <= 1'b0;
        roundsLevel <= rdA[i][0];
        playGame(rounds, frA[i], fpA[i]);
        waitReady();
    endtask

    initial begin
        reset = 1'b1;
        start = 1'b0;
        switches = '0;
        roundsLevel = 1'b0;
        timeLevel = 1'b0;
        resetCheck = 1'b0;
        testNum = 1;
        expOutcome = 0;
        expShows = 0;
        expLimit = 0;
        expRoundsLevel = 1'b0;
        expTimeLevel = 1'b0;
        waitFailed = 0;
        void'($urandom(32'h1ce325c2));
        loadVectors();
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        resetCheck <= 1'b1;
        @(posedge clock);
        resetCheck <= 1'b0;
        for (int i = 0; i < scriptCount && !waitFailed; i++)
            runScript(i);
        @(negedge clock);
        $display("Tests run: %0d, errors: %0d", testCount, errorCount);
        if (errorCount == 0 && !waitFailed && testCount == scriptCount + 1) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/memoryGame_vectors.txt
# R addr colour: sequence ROM image, one-hot colour in hex
# T roundsAtStart roundsInGame timeLevel failRound failPlay outcome (0 won, 1 lost, 2 timeout)
R 0 1
R 1 2
R 2 4
R 3 8
R 4 4
R 5 2
R 6 1
R 7 1
R 8 2
R 9 2
R A 4
R B 4
R C 8
R D 8
R E 1
R F 4
T 0 0 0 FF 0 0
T 0 0 0 2 8 1
T 0 0 0 0 F 2
T 0 0 1 1 F 2
T 1 0 0 FF 0 0

//--- vlog.f
+incdir+include
hw/gamePkg.sv
hw/segmentPkg.sv
hw/sequenceRom.sv
hw/hexDecoder.sv
hw/gameDatapath.sv
hw/gameController.sv
hw/memoryGame.sv
verif/memoryGameChecker.sv
verif/memoryGameTb.sv
